//--- tb.f
rtl/idec_pkg.sv
rtl/apb_insn_port.sv
rtl/decode_lane.sv
rtl/result_bank.sv
rtl/idec_top.sv
test/tb_clock.sv
test/tb_idec.sv

//--- Makefile
# Verilator build and run of the batch decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_idec
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_idec.sv
////////////////////////////////////////
// testbench for the batch decoder, four words per go
// expected values are built from the RV32IM encodings
// illegal words are only checked on illegal, class, rf_we, imm
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_idec;

  import idec_pkg::*;

  typedef struct packed {
    logic [31:0] insn;
    dec_fields_t fields;
    logic [31:0] imm;
    logic        legal;
  } expect_t;

  logic        clk;
  logic        reset;
  apb_req_t    req;
  apb_rsp_t    rsp;
  logic [31:0] lfsr = 32'hd1ea6385;
  expect_t     pend[$];
  int          errors;
  int          checks;
  int          tests;
  int          errors_at_start;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] i12;
  // operators indexed by funct3
  alu_op_e     base_ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e     br_ops [8]   = '{ALU_EQ, ALU_NE, ALU_ADD, ALU_ADD,
                                ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  alu_op_e     md_ops [8]   = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                                ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  // LB LH LW (LD unused) LBU LHU, stores use the first three
  mem_size_e   mem_sizes [6] = '{MEM_BYTE, MEM_HALF, MEM_WORD, MEM_WORD,
                                 MEM_BYTE, MEM_HALF};
  logic        ld_sext [6]   = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};

  tb_clock u_clock (.clk_o(clk), .reset_o(reset));

  idec_top uut (
    .clk_i     (clk),
    .reset_i   (reset),
    .apb_req_i (req),
    .apb_rsp_o (rsp)
  );

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] x);
    return {{20{x[11]}}, x};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] s1,
                                        input logic [2:0] f3, input logic [4:0] d,
                                        input logic [6:0] op);
    return {imm, s1, f3, d, op};
  endfunction

  task automatic draw_fields();
    rd  = 5'(rand_bits(5));
    rs1 = 5'(rand_bits(5));
    rs2 = 5'(rand_bits(5));
    i12 = 12'(rand_bits(12));
  endtask

  ////////////////////////////////////////
  // APB master, one idle cycle between transfers
  ////////////////////////////////////////
  task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: a, pwdata: d};
    @(posedge clk);
    req.penable <= 1'b1;
    @(posedge clk);                 // access completes here
    req <= '0;
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: a, pwdata: 32'h0};
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk);                 // mid access cycle
    d   = rsp.prdata;
    err = rsp.pslverr;
    check_eq("pready", 32'(rsp.pready), 32'h1);
    @(posedge clk);
    req <= '0;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // load slots, go, wait for done, read back every lane
  task automatic run_batch();
    logic [31:0] d;
    logic        e;
    dec_fields_t got;
    int          polls;
    for (int i = 0; i < N_LANES; i++) begin
      apb_write(8'(SLOT_BASE + 4 * i), pend[i].insn);
    end
    apb_write(CTRL_ADDR, 32'h1);
    polls = 0;
    d     = '0;
    while (d[0] !== 1'b1 && polls < 10) begin
      apb_read(STATUS_ADDR, d, e);
      polls++;
    end
    check_eq("prdata status after go", 32'(d[0]), 32'h1);
    for (int i = 0; i < N_LANES; i++) begin
      apb_read(8'(RES_BASE + 8 * i), d, e);
      check_eq("pslverr result read", 32'(e), 32'h0);
      got = dec_fields_t'(d);
      if (pend[i].legal) begin
        check_eq($sformatf("prdata fields, insn %h", pend[i].insn), d, pend[i].fields);
      end else begin
        check_eq($sformatf("prdata illegal/class/rf_we, insn %h", pend[i].insn),
                 32'({got.illegal, got.insn_class, got.rf_we}),
                 32'({1'b1, CLS_ILLEGAL, 1'b0}));
      end
      apb_read(8'(RES_BASE + 8 * i + 4), d, e);
      check_eq($sformatf("prdata imm, insn %h", pend[i].insn), d, pend[i].imm);
    end
    pend.delete();
  endtask

  task automatic queue_check(input logic [31:0] insn, input logic ok,
                             input dec_fields_t f, input logic [31:0] imm);
    pend.push_back('{insn: insn, fields: f, imm: imm, legal: ok});
    if (pend.size() == N_LANES) begin
      run_batch();
    end
  endtask

  task automatic expect_ok(input logic [31:0] insn, input insn_class_e c, input alu_op_e op,
                           input logic we, input logic [31:0] imm,
                           input mem_size_e sz = MEM_WORD, input logic sx = 1'b0,
                           input csr_op_e co = CSR_OP_READ);
    dec_fields_t f;
    f = '{illegal: 1'b0, insn_class: c, alu_op: op, rf_we: we, rd: insn[11:7],
          rs1: insn[19:15], rs2: insn[24:20], mem_size: sz, mem_sext: sx, csr_op: co};
    queue_check(insn, 1'b1, f, imm);
  endtask

  task automatic expect_bad(input logic [31:0] insn);
    queue_check(insn, 1'b0, '0, 32'h0);
  endtask

  // pad with addi x0, x0, 0 so the last batch is full
  task automatic finish_test(input string name);
    while (pend.size() != 0) begin
      expect_ok(32'h0000_0013, CLS_ALU_IMM, ALU_ADD, 1'b1, 32'h0);
    end
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == errors_at_start) ? "passed" : "FAILED");
    errors_at_start = errors;
  endtask

  initial begin
    logic [31:0] d;
    logic        e;
    logic [31:0] w;
    logic [2:0]  f3;
    logic        alt;
    logic [12:0] b13;
    logic [20:0] j21;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    errors_at_start = 0;
    req             = '0;
    @(negedge reset);

    ////////////////////////////////////////
    // apb map, before any go
    ////////////////////////////////////////
    apb_read(STATUS_ADDR, d, e);
    check_eq("prdata status before go", d, 32'h0);
    apb_read(8'h18, d, e);
    check_eq("pslverr at 18", 32'(e), 32'h1);
    apb_read(8'h40, d, e);            // just past the last result word
    check_eq("pslverr at 40", 32'(e), 32'h1);
    for (int i = 0; i < N_LANES; i++) begin
      w = rand_bits(32);
      apb_write(8'(SLOT_BASE + 4 * i), w);
      apb_read(8'(SLOT_BASE + 4 * i), d, e);
      check_eq($sformatf("prdata slot %0d", i), d, w);
    end
    finish_test("apb");

    // OP and OP_IMM alternating
    for (int n = 0; n < 8; n++) begin
      draw_fields();
      f3  = 3'(rand_bits(3));
      alt = 1'(rand_bits(1));
      if (n % 2 == 0) begin
        alt = alt && (f3 == 3'd0 || f3 == 3'd5); // SUB, SRA
        w   = {(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, 7'h33};
        expect_ok(w, CLS_ALU_REG, alt ? (f3 == 3'd0 ? ALU_SUB : ALU_SRA) : base_ops[f3],
                  1'b1, 32'h0);
      end else begin
        alt = alt && (f3 == 3'd5);
        if (f3 == 3'd1 || f3 == 3'd5) begin
          i12[11:5] = {1'b0, alt, 5'b0};         // shamt only
        end
        w = enc_i(i12, rs1, f3, rd, 7'h13);
        expect_ok(w, CLS_ALU_IMM, alt ? ALU_SRA : base_ops[f3], 1'b1, sext12(i12));
      end
    end
    finish_test("arith");

    for (int k = 0; k < 6; k++) begin
      draw_fields();
      if (k != 3) begin
        w = enc_i(i12, rs1, 3'(k), rd, 7'h03);
        expect_ok(w, CLS_LOAD, ALU_ADD, 1'b1, sext12(i12), mem_sizes[k], ld_sext[k]);
      end
    end
    for (int k = 0; k < 3; k++) begin
      draw_fields();
      w = {i12[11:5], rs2, rs1, 3'(k), i12[4:0], 7'h23};
      expect_ok(w, CLS_STORE, ALU_ADD, 1'b0, sext12(i12), mem_sizes[k]);
    end
    for (int k = 0; k < 8; k++) begin
      draw_fields();
      b13 = {12'(rand_bits(12)), 1'b0};
      if (k != 2 && k != 3) begin
        w = {b13[12], b13[10:5], rs2, rs1, 3'(k), b13[4:1], b13[11], 7'h63};
        expect_ok(w, CLS_BRANCH, br_ops[k], 1'b0, {{19{b13[12]}}, b13});
      end
    end
    draw_fields();
    j21 = {20'(rand_bits(20)), 1'b0};
    w   = {j21[20], j21[10:1], j21[11], j21[19:12], rd, 7'h6f};
    expect_ok(w, CLS_JAL, ALU_ADD, 1'b1, {{11{j21[20]}}, j21});
    expect_ok(enc_i(i12, rs1, 3'b000, rd, 7'h67), CLS_JALR, ALU_ADD, 1'b1, sext12(i12));
    w = rand_bits(20);
    expect_ok({w[19:0], rd, 7'h37}, CLS_LUI, ALU_ADD, 1'b1, {w[19:0], 12'h0});
    expect_ok({w[19:0], rs2, 7'h17}, CLS_AUIPC, ALU_ADD, 1'b1, {w[19:0], 12'h0});
    finish_test("memory and control");

    for (int k = 0; k < 8; k++) begin
      draw_fields();
      expect_ok({7'h01, rs2, rs1, 3'(k), rd, 7'h33}, CLS_MULDIV, md_ops[k], 1'b1, 32'h0);
    end
    finish_test("rv32m");

    expect_ok(32'h0000_0073, CLS_ECALL, ALU_ADD, 1'b0, 32'h0);
    expect_ok(32'h0010_0073, CLS_EBREAK, ALU_ADD, 1'b0, 32'h0);
    expect_ok(32'h3020_0073, CLS_MRET, ALU_ADD, 1'b0, 32'h0);
    expect_ok(32'h1050_0073, CLS_WFI, ALU_ADD, 1'b0, 32'h0);
    expect_ok(32'h0ff0_000f, CLS_FENCE, ALU_ADD, 1'b0, 32'h0);
    draw_fields();
    expect_ok(enc_i(i12, rs1, 3'b001, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1, {20'h0, i12},
              MEM_WORD, 1'b0, CSR_OP_WRITE);
    expect_ok(enc_i(i12, rs1 | 5'd1, 3'b010, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1,
              {20'h0, i12}, MEM_WORD, 1'b0, CSR_OP_SET);
    // x0 source turns set and clear into a plain read
    expect_ok(enc_i(i12, 5'd0, 3'b010, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1, {20'h0, i12});
    expect_ok(enc_i(i12, 5'd0, 3'b011, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1, {20'h0, i12});
    expect_ok(enc_i(i12, rs2, 3'b101, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1, {20'h0, i12},
              MEM_WORD, 1'b0, CSR_OP_WRITE);
    expect_ok(enc_i(i12, rs2 | 5'd1, 3'b111, rd, 7'h73), CLS_CSR, ALU_ADD, 1'b1,
              {20'h0, i12}, MEM_WORD, 1'b0, CSR_OP_CLEAR);
    finish_test("system and csr");

    draw_fields();
    expect_bad({25'(rand_bits(25)), 7'h7b});            // no such opcode
    expect_bad({7'h10, rs2, rs1, 3'b101, rd, 7'h13});   // SRAI, bad funct7
    expect_bad(enc_i(i12, rs1, 3'b110, rd, 7'h03));     // LWU
    expect_bad(enc_i(i12, rs1, 3'b001, rd, 7'h67));     // JALR, funct3 1
    expect_bad(32'h0000_00f3);                          // ECALL with rd = 1
    finish_test("illegal");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // six tests, 200 cycles of 20 ns each
  initial begin
    #(6 * 200 * 20);
    $display("timeout, the run did not reach its end in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
////////////////////////////////////////
// free running 20 ns clock
// reset high for the first 16 rising edges
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- rtl/idec_top.sv
////////////////////////////////////////
// batch RV32IM decoder behind APB
// done rises two edges after the go write
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module idec_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  idec_pkg::apb_req_t apb_req_i,
  output idec_pkg::apb_rsp_t apb_rsp_o
);

  import idec_pkg::*;

  logic                      issue;
  logic [N_LANES-1:0][31:0]  slot;
  dec_result_t [N_LANES-1:0] lane_res;
  logic [N_LANES-1:0]        lane_valid;
  dec_result_t [N_LANES-1:0] bank_res;
  logic                      done;

  apb_insn_port u_port (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .issue_o   (issue),
    .slot_o    (slot),
    .results_i (bank_res),
    .done_i    (done)
  );

  // one decoder per slot
  for (genvar i = 0; i < N_LANES; i++) begin : gen_lane
    decode_lane u_lane (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .issue_i  (issue),
      .insn_i   (slot[i]),
      .result_o (lane_res[i]),
      .valid_o  (lane_valid[i])
    );
  end

  result_bank u_bank (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .results_i (lane_res),
    .valid_i   (lane_valid),
    .go_i      (issue),      // clears done one cycle after the go edge
    .results_o (bank_res),
    .done_o    (done)
  );

endmodule

`default_nettype wire

//--- rtl/result_bank.sv
////////////////////////////////////////
// holds the last result of each lane
// done needs every lane valid in one cycle
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module result_bank (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  idec_pkg::dec_result_t [idec_pkg::N_LANES-1:0] results_i,
  input  logic [idec_pkg::N_LANES-1:0]                  valid_i,
  input  logic                                          go_i,
  output idec_pkg::dec_result_t [idec_pkg::N_LANES-1:0] results_o,
  output logic                                          done_o
);

  import idec_pkg::*;

  dec_result_t [N_LANES-1:0] bank_q;
  logic                      done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bank_q <= '0;
    end else begin
      for (int i = 0; i < N_LANES; i++) begin
        if (valid_i[i]) begin
          bank_q[i] <= results_i[i]; // newer batch overwrites
        end
      end
    end
  end

  // a new issue wins over a finishing batch
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else if (go_i) begin
      done_q <= 1'b0;
    end else if (&valid_i) begin
      done_q <= 1'b1;
    end
  end

  assign results_o = bank_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

//--- rtl/decode_lane.sv
////////////////////////////////////////
// registered RV32IM decoder, one word per issue
// illegal words give class ILLEGAL, rf_we low, imm zero
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module decode_lane (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  issue_i,
  input  logic [31:0]           insn_i,
  output idec_pkg::dec_result_t result_o,
  output logic                  valid_o
);

  import idec_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        illegal;
  csr_op_e     csr_op;
  dec_fields_t fld;
  logic [31:0] imm;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  dec_result_t result_q;
  logic        valid_q;

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};
  assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

  ////////////////////////////////////////
  // decoder
  ////////////////////////////////////////
  always_comb begin
    illegal        = 1'b0;
    csr_op         = CSR_OP_READ;
    fld            = '0;
    fld.insn_class = CLS_ILLEGAL;
    fld.alu_op     = ALU_ADD;
    fld.mem_size   = MEM_WORD;
    fld.csr_op     = CSR_OP_READ;
    fld.rd         = insn_i[11:7];
    fld.rs1        = insn_i[19:15];
    fld.rs2        = insn_i[24:20];

    case (opcode)
      OPCODE_JAL: begin
        fld.insn_class = CLS_JAL;
        fld.rf_we      = 1'b1; // link register
      end

      OPCODE_JALR: begin
        fld.insn_class = CLS_JALR;
        fld.rf_we      = 1'b1;
        illegal        = (funct3 != 3'b000);
      end

      OPCODE_BRANCH: begin
        fld.insn_class = CLS_BRANCH;
        case (funct3)
          3'b000:  fld.alu_op = ALU_EQ;
          3'b001:  fld.alu_op = ALU_NE;
          3'b100:  fld.alu_op = ALU_LT;
          3'b101:  fld.alu_op = ALU_GE;
          3'b110:  fld.alu_op = ALU_LTU;
          3'b111:  fld.alu_op = ALU_GEU;
          default: illegal    = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        fld.insn_class = CLS_STORE;
        illegal        = funct3[2];   // no register offset form
        case (funct3[1:0])
          2'b00:   fld.mem_size = MEM_BYTE;
          2'b01:   fld.mem_size = MEM_HALF;
          2'b10:   fld.mem_size = MEM_WORD;
          default: illegal      = 1'b1;
        endcase
      end

      OPCODE_LOAD: begin
        fld.insn_class = CLS_LOAD;
        fld.rf_we      = 1'b1;
        fld.mem_sext   = ~funct3[2];
        case (funct3[1:0])
          2'b00:   fld.mem_size = MEM_BYTE;
          2'b01:   fld.mem_size = MEM_HALF;
          2'b10:   begin
            fld.mem_size = MEM_WORD;
            illegal      = funct3[2]; // LWU
          end
          default: illegal = 1'b1;
        endcase
      end

      OPCODE_LUI: begin
        fld.insn_class = CLS_LUI;
        fld.rf_we      = 1'b1;
      end

      OPCODE_AUIPC: begin
        fld.insn_class = CLS_AUIPC;
        fld.rf_we      = 1'b1;
      end

      OPCODE_OP_IMM: begin
        fld.insn_class = CLS_ALU_IMM;
        fld.rf_we      = 1'b1;
        case (funct3)
          3'b000: fld.alu_op = ALU_ADD;
          3'b010: fld.alu_op = ALU_SLT;
          3'b011: fld.alu_op = ALU_SLTU;
          3'b100: fld.alu_op = ALU_XOR;
          3'b110: fld.alu_op = ALU_OR;
          3'b111: fld.alu_op = ALU_AND;
          3'b001: begin
            fld.alu_op = ALU_SLL;
            illegal    = (funct7 != 7'h00);
          end
          default: begin // 3'b101, SRLI or SRAI by funct7
            if (funct7 == 7'h00) begin
              fld.alu_op = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              fld.alu_op = ALU_SRA;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        fld.rf_we = 1'b1;
        if (funct7 == 7'h01) begin
          fld.insn_class = CLS_MULDIV;
          case (funct3)
            3'b000:  fld.alu_op = ALU_MUL;
            3'b001:  fld.alu_op = ALU_MULH;
            3'b010:  fld.alu_op = ALU_MULHSU;
            3'b011:  fld.alu_op = ALU_MULHU;
            3'b100:  fld.alu_op = ALU_DIV;
            3'b101:  fld.alu_op = ALU_DIVU;
            3'b110:  fld.alu_op = ALU_REM;
            default: fld.alu_op = ALU_REMU;
          endcase
        end else begin
          fld.insn_class = CLS_ALU_REG;
          case ({funct7, funct3})
            {7'h00, 3'b000}: fld.alu_op = ALU_ADD;
            {7'h20, 3'b000}: fld.alu_op = ALU_SUB;
            {7'h00, 3'b010}: fld.alu_op = ALU_SLT;
            {7'h00, 3'b011}: fld.alu_op = ALU_SLTU;
            {7'h00, 3'b100}: fld.alu_op = ALU_XOR;
            {7'h00, 3'b110}: fld.alu_op = ALU_OR;
            {7'h00, 3'b111}: fld.alu_op = ALU_AND;
            {7'h00, 3'b001}: fld.alu_op = ALU_SLL;
            {7'h00, 3'b101}: fld.alu_op = ALU_SRL;
            {7'h20, 3'b101}: fld.alu_op = ALU_SRA;
            default:         illegal    = 1'b1;
          endcase
        end
      end

      OPCODE_MISC_MEM: begin
        fld.insn_class = CLS_FENCE;
        illegal        = (funct3 != 3'b000); // FENCE.I not supported
      end

      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (insn_i[31:20])
            12'h000: fld.insn_class = CLS_ECALL;
            12'h001: fld.insn_class = CLS_EBREAK;
            12'h302: fld.insn_class = CLS_MRET;
            12'h105: fld.insn_class = CLS_WFI;
            default: illegal        = 1'b1;
          endcase
          // rs1 and rd must be zero here
          if (fld.rs1 != 5'd0 || fld.rd != 5'd0) begin
            illegal = 1'b1;
          end
        end else begin
          fld.insn_class = CLS_CSR;
          fld.rf_we      = 1'b1;
          case (funct3[1:0])
            2'b01:   csr_op  = CSR_OP_WRITE;
            2'b10:   csr_op  = CSR_OP_SET;
            2'b11:   csr_op  = CSR_OP_CLEAR;
            default: illegal = 1'b1;
          endcase
          fld.csr_op = csr_op;
          // set/clear with x0 or uimm 0 only reads
          if ((csr_op == CSR_OP_SET || csr_op == CSR_OP_CLEAR) && fld.rs1 == 5'd0) begin
            fld.csr_op = CSR_OP_READ;
          end
        end
      end

      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      fld.insn_class = CLS_ILLEGAL;
      fld.rf_we      = 1'b0;   // no write back from a bad word
    end
    fld.illegal = illegal;
  end

  // immediate by format
  always_comb begin
    case (fld.insn_class)
      CLS_ALU_IMM, CLS_LOAD, CLS_JALR: imm = imm_i;
      CLS_STORE:                       imm = imm_s;
      CLS_BRANCH:                      imm = imm_b;
      CLS_LUI, CLS_AUIPC:              imm = imm_u;
      CLS_JAL:                         imm = imm_j;
      CLS_CSR:                         imm = {20'b0, insn_i[31:20]}; // csr address
      default:                         imm = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= issue_i;
      if (issue_i) begin
        result_q <= '{fields: fld, imm: imm};
      end
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;

endmodule

`default_nettype wire

//--- rtl/apb_insn_port.sv
////////////////////////////////////////
// APB slave, no wait states
// unaligned or unmapped access gives pslverr
// go is bit 0 of CTRL, issue follows one cycle later
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module apb_insn_port (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  idec_pkg::apb_req_t                            apb_req_i,
  output idec_pkg::apb_rsp_t                            apb_rsp_o,
  output logic                                          issue_o,
  output logic [idec_pkg::N_LANES-1:0][31:0]            slot_o,
  input  idec_pkg::dec_result_t [idec_pkg::N_LANES-1:0] results_i,
  input  logic                                          done_i
);

  import idec_pkg::*;

  logic                     access;
  logic                     wr_en;
  logic [ADDR_W-1:0]        addr;
  logic [ADDR_W-1:0]        slot_off;
  logic [ADDR_W-1:0]        res_off;
  logic                     aligned;
  logic                     slot_hit;
  logic                     res_hit;
  logic                     ctrl_hit;
  logic                     status_hit;
  logic                     addr_hit;
  logic [LANE_W-1:0]        slot_idx;
  logic [LANE_W-1:0]        res_idx;
  logic [N_LANES-1:0][31:0] slot_q;
  logic                     issue_q;
  logic [31:0]              rdata;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////
  assign access  = apb_req_i.psel & apb_req_i.penable; // access phase only
  assign wr_en   = access & apb_req_i.pwrite;
  assign addr    = apb_req_i.paddr;
  assign aligned = (addr[1:0] == 2'b00);

  assign slot_off   = addr - SLOT_BASE;
  assign res_off    = addr - RES_BASE;
  assign slot_hit   = aligned && (slot_off < SLOT_SPAN);
  assign res_hit    = aligned && (res_off < RES_SPAN);
  assign ctrl_hit   = (addr == CTRL_ADDR);
  assign status_hit = (addr == STATUS_ADDR);
  assign addr_hit   = slot_hit | res_hit | ctrl_hit | status_hit;

  assign slot_idx = slot_off[2 +: LANE_W]; // 4 bytes per slot
  assign res_idx  = res_off[3 +: LANE_W];  // 8 bytes per lane

  ////////////////////////////////////////
  // slots and go strobe
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_q  <= '0;
      issue_q <= 1'b0;
    end else begin
      issue_q <= wr_en & ctrl_hit & apb_req_i.pwdata[0];
      if (wr_en && slot_hit) begin
        slot_q[slot_idx] <= apb_req_i.pwdata;
      end
    end
  end

  assign issue_o = issue_q;
  assign slot_o  = slot_q;

  // read mux, CTRL reads as zero
  always_comb begin
    rdata = '0;
    if (slot_hit) begin
      rdata = slot_q[slot_idx];
    end else if (res_hit) begin
      if (res_off[2]) begin
        rdata = results_i[res_idx].imm;    // second word of the lane
      end else begin
        rdata = results_i[res_idx].fields;
      end
    end else if (status_hit) begin
      rdata = {31'b0, done_i};
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = rdata;
    apb_rsp_o.pready  = 1'b1;                // never stalls
    apb_rsp_o.pslverr = access & ~addr_hit;
  end

endmodule

`default_nettype wire

//--- rtl/idec_pkg.sv
////////////////////////////////////////
// types and address map of the batch decoder
// slot and result windows must not overlap CTRL and STATUS
// decode covers RV32IM only, no compressed
////////////////////////////////////////
`default_nettype none

package idec_pkg;

  localparam int N_LANES = 4;
  localparam int LANE_W  = $clog2(N_LANES);
  localparam int ADDR_W  = 8;

  ////////////////////////////////////////
  // APB address map
  ////////////////////////////////////////
  localparam logic [ADDR_W-1:0] SLOT_BASE   = 8'h00; // slot i at +4*i
  localparam logic [ADDR_W-1:0] CTRL_ADDR   = 8'h10; // bit 0 = go
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h14; // bit 0 = done
  localparam logic [ADDR_W-1:0] RES_BASE    = 8'h20; // fields at +8*i, imm right after
  localparam logic [ADDR_W-1:0] SLOT_SPAN   = ADDR_W'(4 * N_LANES);
  localparam logic [ADDR_W-1:0] RES_SPAN    = ADDR_W'(8 * N_LANES);

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [4:0] {
    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
    CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_MULDIV, CLS_FENCE, CLS_ECALL,
    CLS_EBREAK, CLS_MRET, CLS_WFI, CLS_CSR, CLS_ILLEGAL
  } insn_class_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU, // branch compares
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR
  } csr_op_e;

  typedef enum logic [1:0] {
    MEM_WORD = 2'd0,
    MEM_HALF = 2'd1,
    MEM_BYTE = 2'd2
  } mem_size_e;

  // 32-bit field word as read back over APB, msb first
  typedef struct packed {
    logic        illegal;
    insn_class_e insn_class;
    alu_op_e     alu_op;
    logic        rf_we;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    mem_size_e   mem_size;
    logic        mem_sext;
    csr_op_e     csr_op;
  } dec_fields_t;

  typedef struct packed {
    dec_fields_t fields;
    logic [31:0] imm;
  } dec_result_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [31:0]       pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
